// ==== source/dispatchPkg.sv ====
package dispatchPkg;

  // Machine configuration
  localparam int DISPATCH_WIDTH    = 4;
  localparam int CHECKPOINTS       = 8;
  localparam int CHECKPOINTS_LOG   = 3;

  localparam int SIZE_PHYSICAL_LOG = 7;
  localparam int SIZE_RMT_LOG      = 5;
  localparam int SIZE_PC           = 32;
  localparam int SIZE_IMMEDIATE    = 16;
  localparam int SIZE_OPCODE       = 8;
  localparam int INST_TYPES_LOG    = 2;
  localparam int LDST_TYPES_LOG    = 2;
  localparam int SIZE_CTI_LOG      = 2;

  // Back-end capacities
  localparam int SIZE_LSQ          = 16; // Each of load queue and store queue
  localparam int SIZE_ISSUEQ       = 32;
  localparam int SIZE_ACTIVELIST   = 64;

  typedef logic [SIZE_PC-1:0]           pc_t;
  typedef logic [SIZE_PHYSICAL_LOG-1:0] physReg_t;
  typedef logic [SIZE_RMT_LOG-1:0]      logReg_t;
  typedef logic [CHECKPOINTS-1:0]       branchMask_t;  // One bit per live checkpoint
  typedef logic [CHECKPOINTS_LOG-1:0]   checkpointId_t;

  // Occupancy counts need one extra bit to reach the full size
  typedef logic [$clog2(SIZE_LSQ):0]        lsqCnt_t;
  typedef logic [$clog2(SIZE_ISSUEQ):0]     iqCnt_t;
  typedef logic [$clog2(SIZE_ACTIVELIST):0] alCnt_t;
  typedef logic [$clog2(DISPATCH_WIDTH):0]  laneCnt_t;

  // Packet from rename, one per lane
  typedef struct packed {
    logReg_t                    logDest;
    logic                       destValid;
    logic                       isStore;
    logic                       isLoad;
    branchMask_t                branchMask;
    checkpointId_t              checkpointId;
    physReg_t                   physDest;
    physReg_t                   physOldDest;
    physReg_t                   physSrc1;
    physReg_t                   physSrc2;
    logic [SIZE_IMMEDIATE-1:0]  immediate;
    logic [LDST_TYPES_LOG-1:0]  ldstType;
    logic [INST_TYPES_LOG-1:0]  instType;
    logic [SIZE_OPCODE-1:0]     opcode;
    pc_t                        pc;
    pc_t                        nextPc;
    logic [SIZE_CTI_LOG-1:0]    ctiIndex;
  } renamedPkt_t;

  // Issue queue entry without the logical destination
  typedef struct packed {
    logic                       destValid;
    logic                       isStore;
    logic                       isLoad;
    branchMask_t                branchMask;  // Already updated for this cycle
    checkpointId_t              checkpointId;
    physReg_t                   physDest;
    physReg_t                   physOldDest;
    physReg_t                   physSrc1;
    physReg_t                   physSrc2;
    logic [SIZE_IMMEDIATE-1:0]  immediate;
    logic [LDST_TYPES_LOG-1:0]  ldstType;
    logic [INST_TYPES_LOG-1:0]  instType;
    logic [SIZE_OPCODE-1:0]     opcode;
    pc_t                        pc;
    pc_t                        nextPc;
    logic [SIZE_CTI_LOG-1:0]    ctiIndex;
  } issueqPkt_t;

  // Active list entry used at retirement
  typedef struct packed {
    logic     isLoad;
    logic     isStore;
    pc_t      nextPc;
    logReg_t  logDest;
    physReg_t physOldDest;  // Freed when this instruction commits
    physReg_t physDest;
    logic     destValid;
  } alPkt_t;

  typedef struct packed {
    branchMask_t branchMask;
    logic        isStore;
    logic        isLoad;
  } lsqPkt_t;

endpackage

// ==== source/dispatchLane.sv ====
`timescale 1ns/1ps

module dispatchLane (
  input  dispatchPkg::renamedPkt_t   renamedPkt_i,
  input  logic                       ctrlVerified_i,
  input  dispatchPkg::checkpointId_t ctrlVerifiedId_i,
  output dispatchPkg::issueqPkt_t    issueqPkt_o,
  output dispatchPkg::alPkt_t        alPkt_o,
  output dispatchPkg::lsqPkt_t       lsqPkt_o,
  output dispatchPkg::branchMask_t   updatedBranchMask_o
);

  dispatchPkg::branchMask_t branchMask;

  // A branch that verifies this cycle frees its checkpoint,
  // so the instructions behind it no longer depend on it
  always_comb begin
    branchMask = renamedPkt_i.branchMask;
    if (ctrlVerified_i) begin
      branchMask[ctrlVerifiedId_i] = 1'b0;
    end
  end

  assign updatedBranchMask_o = branchMask; // Back to the rename/dispatch pipe register

  always_comb begin
    issueqPkt_o.destValid    = renamedPkt_i.destValid;
    issueqPkt_o.isStore      = renamedPkt_i.isStore;
    issueqPkt_o.isLoad       = renamedPkt_i.isLoad;
    issueqPkt_o.branchMask   = branchMask;
    issueqPkt_o.checkpointId = renamedPkt_i.checkpointId;
    issueqPkt_o.physDest     = renamedPkt_i.physDest;
    issueqPkt_o.physOldDest  = renamedPkt_i.physOldDest;
    issueqPkt_o.physSrc1     = renamedPkt_i.physSrc1;
    issueqPkt_o.physSrc2     = renamedPkt_i.physSrc2;
    issueqPkt_o.immediate    = renamedPkt_i.immediate;
    issueqPkt_o.ldstType     = renamedPkt_i.ldstType;
    issueqPkt_o.instType     = renamedPkt_i.instType;
    issueqPkt_o.opcode       = renamedPkt_i.opcode;
    issueqPkt_o.pc           = renamedPkt_i.pc;
    issueqPkt_o.nextPc       = renamedPkt_i.nextPc;
    issueqPkt_o.ctiIndex     = renamedPkt_i.ctiIndex;
  end

  // Active list keeps what commit and recovery need
  always_comb begin
    alPkt_o.isLoad      = renamedPkt_i.isLoad;
    alPkt_o.isStore     = renamedPkt_i.isStore;
    alPkt_o.nextPc      = renamedPkt_i.nextPc;  // Restart point after this instruction
    alPkt_o.logDest     = renamedPkt_i.logDest;
    alPkt_o.physOldDest = renamedPkt_i.physOldDest;
    alPkt_o.physDest    = renamedPkt_i.physDest;
    alPkt_o.destValid   = renamedPkt_i.destValid;
  end

  always_comb begin
    lsqPkt_o.branchMask = branchMask;
    lsqPkt_o.isStore    = renamedPkt_i.isStore;
    lsqPkt_o.isLoad     = renamedPkt_i.isLoad;
  end

endmodule

// ==== source/dispatchAdmit.sv ====
`timescale 1ns/1ps

module dispatchAdmit (
  input  logic                     clk,
  input  logic                     rst_i,

  input  dispatchPkg::issueqPkt_t  issueqPkt_i [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::alPkt_t      alPkt_i     [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::lsqPkt_t     lsqPkt_i    [dispatchPkg::DISPATCH_WIDTH],

  input  logic                     renameReady_i,   // Rename holds a full group
  input  logic                     flagRecoverEX_i,
  input  dispatchPkg::lsqCnt_t     loadQueueCnt_i,
  input  dispatchPkg::lsqCnt_t     storeQueueCnt_i,
  input  dispatchPkg::iqCnt_t      issueQueueCnt_i,
  input  dispatchPkg::alCnt_t      activeListCnt_i,

  output dispatchPkg::issueqPkt_t  issueqPkt_o [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::alPkt_t      alPkt_o     [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::lsqPkt_t     lsqPkt_o    [dispatchPkg::DISPATCH_WIDTH],
  output logic                     dispatchValid_o,
  output logic                     backEndReady_o,
  output logic                     stallFrontEnd_o
);

  dispatchPkg::laneCnt_t loadCnt;
  dispatchPkg::laneCnt_t storeCnt;

  logic loadStall;
  logic storeStall;
  logic issueqStall;
  logic alStall;
  logic spaceStall;

  // Loads and stores in the incoming group
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < dispatchPkg::DISPATCH_WIDTH; i++) begin
      loadCnt  = loadCnt + dispatchPkg::laneCnt_t'(lsqPkt_i[i].isLoad);
      storeCnt = storeCnt + dispatchPkg::laneCnt_t'(lsqPkt_i[i].isStore);
    end
  end

  // The LSQ checks use the exact group mix while IQ and AL reserve a full group
  assign loadStall   = (int'(loadQueueCnt_i) + int'(loadCnt)) > dispatchPkg::SIZE_LSQ;
  assign storeStall  = (int'(storeQueueCnt_i) + int'(storeCnt)) > dispatchPkg::SIZE_LSQ;
  assign issueqStall = (int'(issueQueueCnt_i) + dispatchPkg::DISPATCH_WIDTH) >
                       dispatchPkg::SIZE_ISSUEQ;
  assign alStall     = (int'(activeListCnt_i) + dispatchPkg::DISPATCH_WIDTH) >
                       dispatchPkg::SIZE_ACTIVELIST;

  assign spaceStall = loadStall | storeStall | issueqStall | alStall;

  assign stallFrontEnd_o = spaceStall;
  assign backEndReady_o  = ~spaceStall & renameReady_i & ~flagRecoverEX_i;

  // Back-end latch that the queues write from
  always_ff @(posedge clk) begin
    if (rst_i) begin
      dispatchValid_o <= 1'b0;
      for (int i = 0; i < dispatchPkg::DISPATCH_WIDTH; i++) begin
        issueqPkt_o[i] <= '0;
        alPkt_o[i]     <= '0;
        lsqPkt_o[i]    <= '0;
      end
    end else begin
      dispatchValid_o <= backEndReady_o;
      if (backEndReady_o) begin
        issueqPkt_o <= issueqPkt_i;
        alPkt_o     <= alPkt_i;
        lsqPkt_o    <= lsqPkt_i;
      end
      // Otherwise the last accepted group holds
    end
  end

endmodule

// ==== source/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
  input  logic                       clk,
  input  logic                       rst_i,

  input  dispatchPkg::renamedPkt_t   renamedPkt_i [dispatchPkg::DISPATCH_WIDTH],
  input  logic                       renameReady_i,
  input  logic                       flagRecoverEX_i,
  input  logic                       ctrlVerified_i,
  input  dispatchPkg::checkpointId_t ctrlVerifiedId_i,

  input  dispatchPkg::lsqCnt_t       loadQueueCnt_i,
  input  dispatchPkg::lsqCnt_t       storeQueueCnt_i,
  input  dispatchPkg::iqCnt_t        issueQueueCnt_i,
  input  dispatchPkg::alCnt_t        activeListCnt_i,

  output dispatchPkg::issueqPkt_t    issueqPkt_o [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::alPkt_t        alPkt_o     [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::lsqPkt_t       lsqPkt_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::branchMask_t   updatedBranchMask_o [dispatchPkg::DISPATCH_WIDTH],
  output logic                       dispatchValid_o,
  output logic                       backEndReady_o,
  output logic                       stallFrontEnd_o
);

  // Unlatched packets from the lanes
  dispatchPkg::issueqPkt_t issueqPkt [dispatchPkg::DISPATCH_WIDTH];
  dispatchPkg::alPkt_t     alPkt     [dispatchPkg::DISPATCH_WIDTH];
  dispatchPkg::lsqPkt_t    lsqPkt    [dispatchPkg::DISPATCH_WIDTH];

  for (genvar lane = 0; lane < dispatchPkg::DISPATCH_WIDTH; lane++) begin : genLane
    dispatchLane laneInst (
      .renamedPkt_i        (renamedPkt_i[lane]),
      .ctrlVerified_i      (ctrlVerified_i),
      .ctrlVerifiedId_i    (ctrlVerifiedId_i),
      .issueqPkt_o         (issueqPkt[lane]),
      .alPkt_o             (alPkt[lane]),
      .lsqPkt_o            (lsqPkt[lane]),
      .updatedBranchMask_o (updatedBranchMask_o[lane])
    );
  end

  dispatchAdmit admitInst (
    .clk             (clk),
    .rst_i           (rst_i),
    .issueqPkt_i     (issueqPkt),
    .alPkt_i         (alPkt),
    .lsqPkt_i        (lsqPkt),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .issueqPkt_o     (issueqPkt_o),
    .alPkt_o         (alPkt_o),
    .lsqPkt_o        (lsqPkt_o),
    .dispatchValid_o (dispatchValid_o),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

endmodule

// ==== dv/dispatch_properties.sv ====
`timescale 1ns/1ps

module dispatchProperties (
  input logic clk,
  input logic rst_i,
  input logic dispatchValid_o,
  input logic backEndReady_o,
  input logic stallFrontEnd_o
);

  // Ready requires the space check to pass
  readyNotStalled: assert property (@(posedge clk)
    !(backEndReady_o && stallFrontEnd_o))
    else $error("backEndReady_o and stallFrontEnd_o are high together");

  // Latch valid is the ready of the edge before
  validFollowsReady: assert property (@(posedge clk) disable iff (rst_i)
    !$past(rst_i) |-> (dispatchValid_o == $past(backEndReady_o)))
    else $error("dispatchValid_o does not follow backEndReady_o of the previous cycle");

  validLowInReset: assert property (@(posedge clk)
    rst_i |=> !dispatchValid_o)
    else $error("dispatchValid_o is high after a reset cycle");

endmodule

bind dispatch dispatchProperties props (
  .clk             (clk),
  .rst_i           (rst_i),
  .dispatchValid_o (dispatchValid_o),
  .backEndReady_o  (backEndReady_o),
  .stallFrontEnd_o (stallFrontEnd_o)
);

// ==== dv/dispatchTb.sv ====
`timescale 1ns/1ps

module dispatchTb;

  localparam int W = dispatchPkg::DISPATCH_WIDTH;
  localparam int WAIT_LIMIT = 20;  // Cycles before a wait gives up

  logic                       clk;
  logic                       rst;
  dispatchPkg::renamedPkt_t   renamedPkt [W];
  logic                       renameReady;
  logic                       flagRecover;
  logic                       ctrlVerified;
  dispatchPkg::checkpointId_t ctrlVerifiedId;
  dispatchPkg::lsqCnt_t       loadQueueCnt;
  dispatchPkg::lsqCnt_t       storeQueueCnt;
  dispatchPkg::iqCnt_t        issueQueueCnt;
  dispatchPkg::alCnt_t        activeListCnt;

  dispatchPkg::issueqPkt_t    issueqPkt [W];
  dispatchPkg::alPkt_t        alPkt [W];
  dispatchPkg::lsqPkt_t       lsqPkt [W];
  dispatchPkg::branchMask_t   updatedMask [W];
  logic                       dispatchValid;
  logic                       backEndReady;
  logic                       stallFrontEnd;

  // Group on the inputs and what the back-end latch should hold
  dispatchPkg::renamedPkt_t   curGroup [W];
  dispatchPkg::issueqPkt_t    expIssueq [W];
  dispatchPkg::alPkt_t        expAl [W];
  dispatchPkg::lsqPkt_t       expLsq [W];

  dispatch dut (
    .clk                 (clk),
    .rst_i               (rst),
    .renamedPkt_i        (renamedPkt),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecover),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .issueqPkt_o         (issueqPkt),
    .alPkt_o             (alPkt),
    .lsqPkt_o            (lsqPkt),
    .updatedBranchMask_o (updatedMask),
    .dispatchValid_o     (dispatchValid),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  always #4 clk = ~clk;

  task automatic abortRun();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkIssueq(string name, dispatchPkg::issueqPkt_t expVal,
                             dispatchPkg::issueqPkt_t actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkAl(string name, dispatchPkg::alPkt_t expVal, dispatchPkg::alPkt_t actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkLsq(string name, dispatchPkg::lsqPkt_t expVal, dispatchPkg::lsqPkt_t actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkMask(string name, dispatchPkg::branchMask_t expVal,
                           dispatchPkg::branchMask_t actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkFlag(string name, logic expVal, logic actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH %s expected %b actual %b", name, expVal, actVal);
      abortRun();
    end
  endtask

  // Random payload with the load and store bits set by the caller
  function automatic dispatchPkg::renamedPkt_t makePkt(logic isLd, logic isSt);
    logic [159:0]             raw;
    dispatchPkg::renamedPkt_t pkt;
    raw = {$urandom, $urandom, $urandom, $urandom, $urandom};
    pkt = raw[$bits(dispatchPkg::renamedPkt_t)-1:0];
    pkt.isLoad  = isLd;
    pkt.isStore = isSt;
    return pkt;
  endfunction

  // Loads fill the low lanes and stores the high ones
  task automatic driveGroup(int nLd, int nSt, logic verified, dispatchPkg::checkpointId_t id,
                            logic ready, logic recover);
    @(posedge clk);
    for (int lane = 0; lane < W; lane++) begin
      curGroup[lane] = makePkt(lane < nLd, lane >= W - nSt);
      curGroup[lane].branchMask[id] = 1'b1;  // So a clear of this bit is visible
      renamedPkt[lane] <= curGroup[lane];
    end
    renameReady    <= ready;
    flagRecover    <= recover;
    ctrlVerified   <= verified;
    ctrlVerifiedId <= id;
  endtask

  task automatic setCounts(int lq, int sq, int iq, int al);
    loadQueueCnt  <= dispatchPkg::lsqCnt_t'(lq);
    storeQueueCnt <= dispatchPkg::lsqCnt_t'(sq);
    issueQueueCnt <= dispatchPkg::iqCnt_t'(iq);
    activeListCnt <= dispatchPkg::alCnt_t'(al);
  endtask

  task automatic releaseGroup();
    @(posedge clk);
    renameReady  <= 1'b0;
    flagRecover  <= 1'b0;
    ctrlVerified <= 1'b0;
  endtask

  task automatic waitValid(string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (dispatchValid !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        $display("%s timed out waiting for dispatchValid_o", name);
        abortRun();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic checkLatched(string name);
    for (int lane = 0; lane < W; lane++) begin
      checkIssueq($sformatf("%s lane %0d issueq", name, lane), expIssueq[lane], issueqPkt[lane]);
      checkAl($sformatf("%s lane %0d al", name, lane), expAl[lane], alPkt[lane]);
      checkLsq($sformatf("%s lane %0d lsq", name, lane), expLsq[lane], lsqPkt[lane]);
    end
  endtask

  // A verified branch clears its own bit in every younger mask
  task automatic buildExpected(logic verified, dispatchPkg::checkpointId_t id);
    dispatchPkg::branchMask_t mask;
    for (int lane = 0; lane < W; lane++) begin
      mask = curGroup[lane].branchMask;
      if (verified) mask[id] = 1'b0;
      expIssueq[lane] = curGroup[lane][$bits(dispatchPkg::issueqPkt_t)-1:0];  // All but logDest
      expIssueq[lane].branchMask = mask;
      expAl[lane] = '{isLoad: curGroup[lane].isLoad, isStore: curGroup[lane].isStore,
                      nextPc: curGroup[lane].nextPc, logDest: curGroup[lane].logDest,
                      physOldDest: curGroup[lane].physOldDest,
                      physDest: curGroup[lane].physDest, destValid: curGroup[lane].destValid};
      expLsq[lane] = '{branchMask: mask, isStore: curGroup[lane].isStore,
                       isLoad: curGroup[lane].isLoad};
    end
  endtask

  task automatic acceptGroup(string name, int nLd, int nSt, logic verified,
                             dispatchPkg::checkpointId_t id);
    driveGroup(nLd, nSt, verified, id, 1'b1, 1'b0);
    setCounts(0, 0, 0, 0);
    buildExpected(verified, id);
    @(negedge clk);
    checkFlag({name, " ready"}, 1'b1, backEndReady);
    checkFlag({name, " stall"}, 1'b0, stallFrontEnd);
    for (int lane = 0; lane < W; lane++) begin
      checkMask($sformatf("%s lane %0d mask", name, lane), expLsq[lane].branchMask,
                updatedMask[lane]);
    end
    releaseGroup();
    waitValid(name);
    checkLatched(name);
  endtask

  task automatic spaceCheck(string name, int nLd, int nSt, int lq, int sq, int iq, int al,
                            logic expStall);
    driveGroup(nLd, nSt, 1'b0, '0, 1'b1, 1'b0);
    setCounts(lq, sq, iq, al);
    @(negedge clk);
    checkFlag({name, " stall"}, expStall, stallFrontEnd);
    checkFlag({name, " ready"}, !expStall, backEndReady);
    releaseGroup();
  endtask

  // Group is refused without a stall while the latch keeps the last group
  task automatic holdGroup(string name, logic ready, logic recover);
    driveGroup(0, 0, 1'b0, '0, ready, recover);
    setCounts(0, 0, 0, 0);
    @(negedge clk);
    checkFlag({name, " ready"}, 1'b0, backEndReady);
    checkFlag({name, " stall"}, 1'b0, stallFrontEnd);
    @(negedge clk);
    checkFlag({name, " valid"}, 1'b0, dispatchValid);
    checkLatched(name);
    releaseGroup();
  endtask

  initial begin
    void'($urandom(45));
    clk = 1'b0;
    rst = 1'b1;
    renameReady = 1'b0;
    flagRecover = 1'b0;
    ctrlVerified = 1'b0;
    ctrlVerifiedId = '0;
    loadQueueCnt = '0;
    storeQueueCnt = '0;
    issueQueueCnt = '0;
    activeListCnt = '0;
    for (int lane = 0; lane < W; lane++) begin
      renamedPkt[lane] = '0;
      expIssueq[lane] = '0;
      expAl[lane] = '0;
      expLsq[lane] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkFlag("reset valid", 1'b0, dispatchValid);
    checkLatched("reset");

    acceptGroup("basic", 1, 1, 1'b0, '0);
    acceptGroup("maskVerified", 1, 2, 1'b1, dispatchPkg::checkpointId_t'($urandom));
    acceptGroup("maskKept", 2, 0, 1'b0, 3'd5);

    spaceCheck("loadFits", 2, 0, dispatchPkg::SIZE_LSQ - 2, 0, 0, 0, 1'b0);
    spaceCheck("loadFull", 2, 0, dispatchPkg::SIZE_LSQ - 1, 0, 0, 0, 1'b1);
    spaceCheck("storeFits", 0, 2, 0, dispatchPkg::SIZE_LSQ - 2, 0, 0, 1'b0);
    spaceCheck("storeFull", 0, 2, 0, dispatchPkg::SIZE_LSQ - 1, 0, 0, 1'b1);
    spaceCheck("issueqFits", 1, 1, 0, 0, dispatchPkg::SIZE_ISSUEQ - W, 0, 1'b0);
    spaceCheck("issueqFull", 1, 1, 0, 0, dispatchPkg::SIZE_ISSUEQ - W + 1, 0, 1'b1);
    spaceCheck("alFits", 1, 1, 0, 0, 0, dispatchPkg::SIZE_ACTIVELIST - W, 1'b0);
    spaceCheck("alFull", 1, 1, 0, 0, 0, dispatchPkg::SIZE_ACTIVELIST - W + 1, 1'b1);

    acceptGroup("beforeHold", 2, 1, 1'b0, '0);
    holdGroup("recovery", 1'b1, 1'b1);
    holdGroup("renameNotReady", 1'b0, 1'b0);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== dispatch.f ====
source/dispatchPkg.sv
source/dispatchLane.sv
source/dispatchAdmit.sv
source/dispatch.sv
dv/dispatch_properties.sv
dv/dispatchTb.sv

// ==== Makefile ====
# Verilator simulation of the dispatch stage

VERILATOR ?= verilator
TOP       ?= dispatchTb
FILELIST  ?= dispatch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
